// File: list.f
mci_pkg.sv
mci_in_sync.sv
mci_csr_wb.sv
mci_boot_seqr.sv
mci_top.sv
tb_mci.sv

// File: run.sh
#!/bin/sh
# Compile and run the MCI boot testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mci -f list.f \
  && ./obj_dir/Vtb_mci | tee /dev/stderr | grep -q "^No errors$" \
  && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }

// File: tb_mci.sv
/*
 * Testbench for the MCI boot subsystem: clock and resets, scenario table,
 * FC/LCC/MCU models, Wishbone access tasks, compare tasks and run timeout
 */
module tb_mci
  import mci_pkg::*;
();

  typedef struct packed {
    logic                brkpoint;
    logic                no_rom;
    logic                fw_update;
    logic                warm_rst;
    mci_boot_fsm_state_e hold_state;
    logic                mcu_at_cptra_go;
    logic                exp_halt;
    logic                early_lock;
  } scenario_t;

  localparam int NUM_SCEN       = 5;
  localparam int TIMEOUT_CYCLES = NUM_SCEN * 400;
  localparam int MIN_RST_CYCLES = 2 ** MIN_MCU_RST_CNT_W;

  // Selectors for the level waits
  localparam int SIG_FC_INIT    = 0;
  localparam int SIG_LC_INIT    = 1;
  localparam int SIG_SS_RST_B   = 2;
  localparam int SIG_MCU_RST_B  = 3;
  localparam int SIG_CPTRA_RST  = 4;
  localparam int SIG_HALT_REQ   = 5;
  localparam int SIG_RDC_CLKDIS = 6;
  localparam int SIG_FW_CLKDIS  = 7;

  logic        clk;
  logic        mci_pwrgood;
  logic        mci_rst_b;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        brkpoint;
  logic        no_rom_config;
  logic        halt_ack    = 1'b0;
  logic        halt_status = 1'b0;
  logic        fc_done     = 1'b0;
  logic        lc_done     = 1'b0;
  logic        fc_init;
  logic        lc_init;
  logic        mcu_halt_req;
  logic        ss_rst_b;
  logic        mcu_rst_b;
  logic        cptra_rst_b;
  logic        rdc_clk_dis;
  logic        fw_clk_dis;
  logic [15:0] lfsr = 16'd43;
  int          fc_cnt  = -1;
  int          lc_cnt  = -1;
  int          ack_cnt = -1;
  int          sts_cnt = -1;
  int          cycle_cnt = 0;
  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  scenario_t   scen_tbl [NUM_SCEN];

  mci_top dut0 (
    .clk                 (clk),
    .mci_pwrgood         (mci_pwrgood),
    .mci_rst_b           (mci_rst_b),
    .wb_i                (wb_req),
    .wb_o                (wb_rsp),
    .brkpoint_i          (brkpoint),
    .no_rom_config_i     (no_rom_config),
    .mcu_halt_ack_i      (halt_ack),
    .mcu_halt_status_i   (halt_status),
    .fc_init_o           (fc_init),
    .fc_done_i           (fc_done),
    .lc_init_o           (lc_init),
    .lc_done_i           (lc_done),
    .mcu_halt_req_o      (mcu_halt_req),
    .ss_rst_b_o          (ss_rst_b),
    .mcu_rst_b_o         (mcu_rst_b),
    .cptra_rst_b_o       (cptra_rst_b),
    .rdc_clk_dis_o       (rdc_clk_dis),
    .fw_update_clk_dis_o (fw_clk_dis)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////
  // Device models
  ////////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // Answer delay of 1 to 8 cycles from three LFSR bits
  function automatic int rand_delay();
    int d;
    d = 0;
    for (int i = 0; i < 3; i++) begin
      d = (d << 1) | int'(lfsr_bit());
    end
    return d + 1;
  endfunction

  // Raise done some cycles after req, drop it as soon as req goes away
  function automatic void answer(input logic req, inout logic done, inout int cnt);
    if (!req) begin
      done = 1'b0;
      cnt  = -1;
    end else if (!done) begin
      if (cnt < 0) begin
        cnt = rand_delay();
      end else if (cnt > 1) begin
        cnt = cnt - 1;
      end else begin
        done = 1'b1;
      end
    end
  endfunction

  // MCU keeps its ack and halted status until it is put in reset
  always @(negedge clk) begin
    answer(fc_init, fc_done, fc_cnt);
    answer(lc_init, lc_done, lc_cnt);
    answer(mcu_rst_b && (mcu_halt_req || halt_ack), halt_ack, ack_cnt);
    answer(mcu_rst_b && halt_ack, halt_status, sts_cnt);
  end

  ////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////

  task automatic cmp_state(input string name, input mci_boot_fsm_state_e got,
                           input mci_boot_fsm_state_e exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic cmp_data(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    @(negedge clk);
    while (!wb_rsp.ack && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_rsp.ack) begin
      $display("Wishbone access to address 0x%h was never acknowledged", adr);
      fail_cnt++;
    end
    rdat = wb_rsp.dat;
    // Transfer ends on the edge that samples ack
    @(negedge clk);
    wb_req = '0;
    cmp_bit("wb_o.ack", wb_rsp.ack, 1'b0);
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  function automatic wb_data_t ctrl_word(input logic go, input logic cptra,
                                         input logic req, input logic lock);
    wb_data_t w;
    w = '0;
    w[CTRL_BOOTFSM_GO]  = go;
    w[CTRL_CPTRA_GO]    = cptra;
    w[CTRL_MCU_RST_REQ] = req;
    w[CTRL_REGION_LOCK] = lock;
    return w;
  endfunction

  function automatic wb_data_t status_word(input mci_boot_fsm_state_e state,
                                           input logic once, input logic ss,
                                           input logic mcu, input logic cptra);
    wb_data_t w;
    w = '0;
    w[STAT_STATE_LSB +: 4] = state;
    w[STAT_MCU_RST_ONCE]   = once;
    w[STAT_SS_RST_B]       = ss;
    w[STAT_MCU_RST_B]      = mcu;
    w[STAT_CPTRA_RST_B]    = cptra;
    return w;
  endfunction

  ////////////////////////////////////////////////////
  // Waits
  ////////////////////////////////////////////////////

  function automatic logic probe(input int sel);
    case (sel)
      SIG_FC_INIT:    return fc_init;
      SIG_LC_INIT:    return lc_init;
      SIG_SS_RST_B:   return ss_rst_b;
      SIG_MCU_RST_B:  return mcu_rst_b;
      SIG_CPTRA_RST:  return cptra_rst_b;
      SIG_HALT_REQ:   return mcu_halt_req;
      SIG_RDC_CLKDIS: return rdc_clk_dis;
      default:        return fw_clk_dis;
    endcase
  endfunction

  function automatic string sig_name(input int sel);
    case (sel)
      SIG_FC_INIT:    return "fc_init_o";
      SIG_LC_INIT:    return "lc_init_o";
      SIG_SS_RST_B:   return "ss_rst_b_o";
      SIG_MCU_RST_B:  return "mcu_rst_b_o";
      SIG_CPTRA_RST:  return "cptra_rst_b_o";
      SIG_HALT_REQ:   return "mcu_halt_req_o";
      SIG_RDC_CLKDIS: return "rdc_clk_dis_o";
      default:        return "fw_update_clk_dis_o";
    endcase
  endfunction

  task automatic wait_until(input int sel, input logic val, input int limit);
    int n;
    n = 0;
    while (probe(sel) !== val && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (probe(sel) !== val) begin
      $display("%s never went to %0b within %0d cycles", sig_name(sel), val, limit);
      fail_cnt++;
    end
  endtask

  // Poll STATUS until the FSM reports the target state
  task automatic wait_state(input mci_boot_fsm_state_e target, input int polls);
    wb_data_t d;
    int       n;
    n = 0;
    wb_read(ADDR_STATUS, d);
    while (mci_boot_fsm_state_e'(d[STAT_STATE_LSB +: 4]) != target && n < polls) begin
      wb_read(ADDR_STATUS, d);
      n++;
    end
    cmp_state("STATUS.state", mci_boot_fsm_state_e'(d[STAT_STATE_LSB +: 4]), target);
  endtask

  ////////////////////////////////////////////////////
  // Scenario steps
  ////////////////////////////////////////////////////

  task automatic cold_reset();
    @(negedge clk);
    mci_pwrgood = 1'b0;
    mci_rst_b   = 1'b0;
    wb_req      = '0;
    repeat (8) @(negedge clk);
    cmp_bit("ss_rst_b_o", ss_rst_b, 1'b0);
    cmp_bit("mcu_rst_b_o", mcu_rst_b, 1'b0);
    cmp_bit("cptra_rst_b_o", cptra_rst_b, 1'b0);
    cmp_bit("fc_init_o", fc_init, 1'b0);
    cmp_bit("lc_init_o", lc_init, 1'b0);
    cmp_bit("mcu_halt_req_o", mcu_halt_req, 1'b0);
    cmp_bit("rdc_clk_dis_o", rdc_clk_dis, 1'b1);
    mci_pwrgood = 1'b1;
    mci_rst_b   = 1'b1;
  endtask

  task automatic warm_reset();
    // Clear the levels so the new boot stops at its go points
    wb_write(ADDR_CTRL, '0);
    @(negedge clk);
    mci_rst_b = 1'b0;
    wait_until(SIG_RDC_CLKDIS, 1'b1, 6);
    wait_until(SIG_SS_RST_B, 1'b0, 8);
    wait_until(SIG_MCU_RST_B, 1'b0, 8);
    wait_until(SIG_CPTRA_RST, 1'b0, 8);
    @(negedge clk);
    mci_rst_b = 1'b1;
    wait_until(SIG_RDC_CLKDIS, 1'b0, 8);
  endtask

  task automatic check_registers();
    wb_data_t d;
    wb_write(ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b1, 1'b1));
    wb_read(ADDR_CTRL, d);
    cmp_data("CTRL", d, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
    wb_read(wb_addr_t'(7), d);
    cmp_data("unmapped register", d, '0);
    // Only undefined bits set
    wb_write(ADDR_CTRL, 32'hffff_fff0);
    wb_read(ADDR_CTRL, d);
    cmp_data("CTRL", d, '0);
    wb_read(ADDR_STATUS, d);
    cmp_state("STATUS.state", mci_boot_fsm_state_e'(d[STAT_STATE_LSB +: 4]),
              BOOT_WAIT_CPTRA_GO);
  endtask

  task automatic fw_update(input logic exp_halt, input logic early_lock);
    wb_data_t d;
    int       start;
    // With the lock already set, only the minimum reset time holds the MCU
    wb_write(ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b1, early_lock));
    if (exp_halt) begin
      wait_until(SIG_HALT_REQ, 1'b1, 10);
      cmp_bit("mcu_rst_b_o", mcu_rst_b, 1'b1);
    end
    wait_until(SIG_FW_CLKDIS, 1'b1, 60);
    wait_until(SIG_MCU_RST_B, 1'b0, 4);
    start = cycle_cnt;
    cmp_bit("fw_update_clk_dis_o", fw_clk_dis, 1'b1);
    cmp_bit("mcu_halt_req_o", mcu_halt_req, 1'b0);
    if (!early_lock) begin
      // Well past the minimum time, still held for the lock
      repeat (MIN_RST_CYCLES + 4) begin
        @(negedge clk);
        cmp_bit("mcu_rst_b_o", mcu_rst_b, 1'b0);
      end
      wb_write(ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b0, 1'b1));
    end
    wait_until(SIG_MCU_RST_B, 1'b1, MIN_RST_CYCLES + 10);
    if (cycle_cnt - start < MIN_RST_CYCLES) begin
      $display("MCU reset was released after only %0d cycles", cycle_cnt - start);
      fail_cnt++;
    end
    wait_state(BOOT_WAIT_MCU_RST_REQ, 5);
    wb_read(ADDR_STATUS, d);
    cmp_data("STATUS", d, status_word(BOOT_WAIT_MCU_RST_REQ, 1'b1, 1'b1, 1'b1, 1'b1));
    cmp_bit("fw_update_clk_dis_o", fw_clk_dis, 1'b0);
  endtask

  task automatic run_scenario(input int idx);
    scenario_t s;
    wb_data_t  d;
    s = scen_tbl[idx];
    @(negedge clk);
    brkpoint      = s.brkpoint;
    no_rom_config = s.no_rom;
    if (s.warm_rst) begin
      warm_reset();
    end else begin
      cold_reset();
    end
    // FC first with the subsystem out of reset, then LCC
    wait_until(SIG_FC_INIT, 1'b1, 20);
    cmp_bit("ss_rst_b_o", ss_rst_b, 1'b1);
    cmp_bit("lc_init_o", lc_init, 1'b0);
    wait_until(SIG_LC_INIT, 1'b1, 20);
    cmp_bit("fc_init_o", fc_init, 1'b1);
    wait_state(s.hold_state, 10);
    if (s.brkpoint) begin
      repeat (3) begin
        wb_read(ADDR_STATUS, d);
        cmp_state("STATUS.state", mci_boot_fsm_state_e'(d[STAT_STATE_LSB +: 4]),
                  BOOT_BREAKPOINT);
        cmp_bit("mcu_rst_b_o", mcu_rst_b, 1'b0);
      end
      wb_write(ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0));
      wait_state(BOOT_WAIT_CPTRA_GO, 5);
    end
    cmp_bit("mcu_rst_b_o", mcu_rst_b, s.mcu_at_cptra_go);
    cmp_bit("cptra_rst_b_o", cptra_rst_b, 1'b0);
    if (idx == 0) begin
      check_registers();
    end
    wb_write(ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0));
    wait_until(SIG_CPTRA_RST, 1'b1, 10);
    wait_state(BOOT_WAIT_MCU_RST_REQ, 5);
    cmp_bit("mcu_rst_b_o", mcu_rst_b, s.mcu_at_cptra_go);
    wb_read(ADDR_CTRL, d);
    cmp_data("CTRL", d, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0));
    if (s.fw_update) begin
      fw_update(s.exp_halt, s.early_lock);
    end
  endtask

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    mci_pwrgood   = 1'b0;
    mci_rst_b     = 1'b0;
    wb_req        = '0;
    brkpoint      = 1'b0;
    no_rom_config = 1'b0;
    // brkpoint, no_rom, fw_update, warm_rst, hold state, mcu at cptra go, halt, early lock
    scen_tbl[0] = '{1'b0, 1'b0, 1'b1, 1'b0, BOOT_WAIT_CPTRA_GO, 1'b1, 1'b1, 1'b0};
    scen_tbl[1] = '{1'b1, 1'b0, 1'b0, 1'b1, BOOT_BREAKPOINT,    1'b1, 1'b0, 1'b0};
    scen_tbl[2] = '{1'b0, 1'b1, 1'b1, 1'b1, BOOT_WAIT_CPTRA_GO, 1'b0, 1'b0, 1'b0};
    scen_tbl[3] = '{1'b1, 1'b1, 1'b1, 1'b0, BOOT_BREAKPOINT,    1'b0, 1'b0, 1'b1};
    scen_tbl[4] = '{1'b0, 1'b0, 1'b1, 1'b1, BOOT_WAIT_CPTRA_GO, 1'b1, 1'b1, 1'b1};
    for (int i = 0; i < NUM_SCEN; i++) begin
      run_scenario(i);
    end
    $display("%0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    fail_cnt++;
    $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("%0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    $display("Errors found");
    $finish;
  end

endmodule

// File: mci_top.sv
/*
 * MCI boot subsystem top: pin synchronizers, Wishbone registers
 * and the boot sequencer
 */
module mci_top
  import mci_pkg::*;
(
  input  logic    clk,
  input  logic    mci_pwrgood,
  input  logic    mci_rst_b,

  // Wishbone slave
  input  wb_req_t wb_i,
  output wb_rsp_t wb_o,

  // Asynchronous SoC pins
  input  logic    brkpoint_i,
  input  logic    no_rom_config_i,
  input  logic    mcu_halt_ack_i,
  input  logic    mcu_halt_status_i,

  // FC and LCC handshakes
  output logic    fc_init_o,
  input  logic    fc_done_i,
  output logic    lc_init_o,
  input  logic    lc_done_i,

  // Resets and clock controls
  output logic    mcu_halt_req_o,
  output logic    ss_rst_b_o,
  output logic    mcu_rst_b_o,
  output logic    cptra_rst_b_o,
  output logic    rdc_clk_dis_o,
  output logic    fw_update_clk_dis_o
);

  soc_sync_t    soc_sync;
  boot_ctrl_t   boot_ctrl;
  boot_status_t boot_status;

  mci_in_sync u_sync (
    .clk             (clk),
    .mci_pwrgood     (mci_pwrgood),
    .mci_rst_b       (mci_rst_b),
    .brkpoint_i      (brkpoint_i),
    .no_rom_config_i (no_rom_config_i),
    .halt_ack_i      (mcu_halt_ack_i),
    .halt_status_i   (mcu_halt_status_i),
    .sync_o          (soc_sync)
  );

  mci_csr_wb u_csr (
    .clk         (clk),
    .mci_pwrgood (mci_pwrgood),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .status_i    (boot_status),
    .ctrl_o      (boot_ctrl)
  );

  mci_boot_seqr u_seqr (
    .clk                 (clk),
    .mci_pwrgood         (mci_pwrgood),
    .sync_i              (soc_sync),
    .ctrl_i              (boot_ctrl),
    .fc_done_i           (fc_done_i),
    .lc_done_i           (lc_done_i),
    .fc_init_o           (fc_init_o),
    .lc_init_o           (lc_init_o),
    .ss_rst_b_o          (ss_rst_b_o),
    .mcu_rst_b_o         (mcu_rst_b_o),
    .cptra_rst_b_o       (cptra_rst_b_o),
    .mcu_halt_req_o      (mcu_halt_req_o),
    .rdc_clk_dis_o       (rdc_clk_dis_o),
    .fw_update_clk_dis_o (fw_update_clk_dis_o),
    .status_o            (boot_status)
  );

endmodule

// File: mci_boot_seqr.sv
/*
 * Boot sequencer: boot FSM, FC/LCC init, reset releases, MCU halt
 * handshake and minimum MCU reset timer for firmware update
 */
module mci_boot_seqr
  import mci_pkg::*;
(
  input  logic         clk,
  input  logic         mci_pwrgood,
  input  soc_sync_t    sync_i,
  input  boot_ctrl_t   ctrl_i,
  input  logic         fc_done_i,
  input  logic         lc_done_i,
  output logic         fc_init_o,
  output logic         lc_init_o,
  output logic         ss_rst_b_o,
  output logic         mcu_rst_b_o,
  output logic         cptra_rst_b_o,
  output logic         mcu_halt_req_o,
  output logic         rdc_clk_dis_o,
  output logic         fw_update_clk_dis_o,
  output boot_status_t status_o
);

  mci_boot_fsm_state_e state_q;
  mci_boot_fsm_state_e state_nxt;
  mci_boot_fsm_state_e state_prev;

  logic     fc_init_nxt;
  logic     lc_init_nxt;
  logic     ss_rst_b_nxt;
  logic     mcu_rst_b_nxt;
  logic     cptra_rst_b_nxt;
  logic     halt_req_nxt;
  logic     reset_once_q;
  logic     reset_once_nxt;
  rst_cnt_t rst_cnt_q;
  rst_cnt_t rst_cnt_nxt;
  logic     rst_elapsed_q;
  logic     rst_elapsed_nxt;

  // Warm reset window gates the clocks of the reset domains
  assign rdc_clk_dis_o       = sync_i.warm_rst_window;
  assign fw_update_clk_dis_o = (state_q == BOOT_RST_MCU) || (state_nxt == BOOT_RST_MCU);

  ////////////////////////////////////////////////////
  // State and output registers
  ////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge mci_pwrgood) begin
    if (!mci_pwrgood) begin
      state_q        <= BOOT_IDLE;
      state_prev     <= BOOT_IDLE;
      fc_init_o      <= 1'b0;
      lc_init_o      <= 1'b0;
      ss_rst_b_o     <= 1'b0;
      mcu_rst_b_o    <= 1'b0;
      cptra_rst_b_o  <= 1'b0;
      mcu_halt_req_o <= 1'b0;
      reset_once_q   <= 1'b0;
      rst_cnt_q      <= '0;
      rst_elapsed_q  <= 1'b0;
    end else begin
      state_q        <= sync_i.warm_rst_window ? BOOT_IDLE : state_nxt;
      // Remember where the FSM came from, BOOT_MCU branches on it
      if (state_q != state_nxt) begin
        state_prev <= state_q;
      end
      fc_init_o      <= fc_init_nxt;
      lc_init_o      <= lc_init_nxt;
      ss_rst_b_o     <= ss_rst_b_nxt;
      mcu_rst_b_o    <= mcu_rst_b_nxt;
      cptra_rst_b_o  <= cptra_rst_b_nxt;
      mcu_halt_req_o <= halt_req_nxt;
      reset_once_q   <= reset_once_nxt;
      rst_cnt_q      <= rst_cnt_nxt;
      rst_elapsed_q  <= rst_elapsed_nxt;
    end
  end

  ////////////////////////////////////////////////////
  // Boot FSM
  ////////////////////////////////////////////////////

  always_comb begin
    state_nxt       = state_q;
    fc_init_nxt     = fc_init_o;
    lc_init_nxt     = lc_init_o;
    ss_rst_b_nxt    = ss_rst_b_o;
    mcu_rst_b_nxt   = mcu_rst_b_o;
    cptra_rst_b_nxt = cptra_rst_b_o;
    reset_once_nxt  = reset_once_q;
    halt_req_nxt    = 1'b0;
    case (state_q)
      BOOT_IDLE: begin
        // Only reached on reset, so put everything back in reset
        state_nxt       = BOOT_OTP_FC;
        fc_init_nxt     = 1'b0;
        lc_init_nxt     = 1'b0;
        ss_rst_b_nxt    = 1'b0;
        mcu_rst_b_nxt   = 1'b0;
        cptra_rst_b_nxt = 1'b0;
      end
      BOOT_OTP_FC: begin
        ss_rst_b_nxt = 1'b1;
        fc_init_nxt  = 1'b1;
        if (fc_done_i) begin
          state_nxt = BOOT_LCC;
        end
      end
      BOOT_LCC: begin
        lc_init_nxt = 1'b1;
        if (lc_done_i) begin
          state_nxt = BOOT_BREAKPOINT_CHECK;
        end
      end
      BOOT_BREAKPOINT_CHECK: begin
        if (sync_i.brkpoint) begin
          state_nxt = BOOT_BREAKPOINT;
        end else if (sync_i.no_rom_config) begin
          state_nxt = BOOT_WAIT_CPTRA_GO;
        end else begin
          state_nxt = BOOT_MCU;
        end
      end
      BOOT_BREAKPOINT: begin
        // Held here until firmware writes the go bit
        if (ctrl_i.bootfsm_go) begin
          state_nxt = sync_i.no_rom_config ? BOOT_WAIT_CPTRA_GO : BOOT_MCU;
        end
      end
      BOOT_MCU: begin
        mcu_rst_b_nxt = 1'b1;
        if (state_prev == BOOT_RST_MCU) begin
          state_nxt = BOOT_WAIT_MCU_RST_REQ;
        end else begin
          state_nxt = BOOT_WAIT_CPTRA_GO;
        end
      end
      BOOT_WAIT_CPTRA_GO: begin
        if (ctrl_i.cptra_boot_go) begin
          state_nxt = BOOT_CPTRA;
        end
      end
      BOOT_CPTRA: begin
        cptra_rst_b_nxt = 1'b1;
        state_nxt       = BOOT_WAIT_MCU_RST_REQ;
      end
      BOOT_WAIT_MCU_RST_REQ: begin
        // An MCU already in reset has nothing to halt
        if (ctrl_i.mcu_rst_req) begin
          state_nxt = mcu_rst_b_o ? BOOT_HALT_MCU : BOOT_RST_MCU;
        end
      end
      BOOT_HALT_MCU: begin
        halt_req_nxt = 1'b1;
        if (sync_i.halt_ack) begin
          state_nxt = BOOT_WAIT_MCU_HALTED;
        end
      end
      BOOT_WAIT_MCU_HALTED: begin
        if (sync_i.halt_status) begin
          state_nxt = BOOT_RST_MCU;
        end
      end
      BOOT_RST_MCU: begin
        mcu_rst_b_nxt  = 1'b0;
        reset_once_nxt = 1'b1;
        // Release after the minimum time and once the new image is locked
        if (rst_elapsed_q && ctrl_i.region_lock) begin
          state_nxt = BOOT_MCU;
        end
      end
      default: begin
        state_nxt = BOOT_UNKNOWN;
      end
    endcase
  end

  ////////////////////////////////////////////////////
  // Minimum MCU reset timer
  ////////////////////////////////////////////////////

  always_comb begin
    rst_cnt_nxt     = rst_cnt_q;
    rst_elapsed_nxt = rst_elapsed_q;
    if (state_nxt == BOOT_RST_MCU && state_q != BOOT_RST_MCU) begin
      // Entering reset, restart the count
      rst_cnt_nxt     = '0;
      rst_elapsed_nxt = 1'b0;
    end else if (state_q == BOOT_RST_MCU && rst_cnt_q != '1) begin
      rst_cnt_nxt = rst_cnt_q + 1'b1;
    end else if (state_q == BOOT_RST_MCU) begin
      rst_elapsed_nxt = 1'b1;
    end
  end

  assign status_o.state          = state_q;
  assign status_o.mcu_reset_once = reset_once_q;
  assign status_o.ss_rst_b       = ss_rst_b_o;
  assign status_o.mcu_rst_b      = mcu_rst_b_o;
  assign status_o.cptra_rst_b    = cptra_rst_b_o;

  ////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////

  a_state_valid: assert property (
    @(posedge clk) disable iff (!mci_pwrgood)
    state_q != BOOT_UNKNOWN
  );

  // Halt is only requested from a running MCU
  a_halt_needs_mcu: assert property (
    @(posedge clk) disable iff (!mci_pwrgood)
    mcu_halt_req_o |-> mcu_rst_b_o
  );

  // Caliptra comes out of reset only inside a live subsystem
  a_cptra_after_ss: assert property (
    @(posedge clk) disable iff (!mci_pwrgood)
    $rose(cptra_rst_b_o) |-> ss_rst_b_o
  );

endmodule

// File: mci_csr_wb.sv
/*
 * Wishbone classic register slave: CTRL levels and go pulses,
 * STATUS readback of the boot sequencer
 */
module mci_csr_wb
  import mci_pkg::*;
(
  input  logic         clk,
  input  logic         mci_pwrgood,
  input  wb_req_t      wb_i,
  output wb_rsp_t      wb_o,
  input  boot_status_t status_i,
  output boot_ctrl_t   ctrl_o
);

  logic     ack_q;
  logic     req_fire;
  logic     wr_ctrl;
  logic     pulse_fire;
  logic     cptra_go_q;
  logic     region_lock_q;
  logic     bootfsm_go_q;
  logic     mcu_rst_req_q;
  wb_data_t rd_data;
  wb_data_t rd_q;

  ////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////

  // New transfer seen while no ack is out
  assign req_fire = wb_i.cyc && wb_i.stb && !ack_q;
  assign wr_ctrl  = req_fire && wb_i.we && (wb_i.adr == ADDR_CTRL);

  // Master still holds the write during the ack cycle
  assign pulse_fire = ack_q && wb_i.cyc && wb_i.stb && wb_i.we && (wb_i.adr == ADDR_CTRL);

  always_ff @(posedge clk or negedge mci_pwrgood) begin
    if (!mci_pwrgood) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_fire;
    end
  end

  ////////////////////////////////////////////////////
  // CTRL register
  ////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge mci_pwrgood) begin
    if (!mci_pwrgood) begin
      cptra_go_q    <= 1'b0;
      region_lock_q <= 1'b0;
    end else if (wr_ctrl) begin
      cptra_go_q    <= wb_i.dat[CTRL_CPTRA_GO];
      region_lock_q <= wb_i.dat[CTRL_REGION_LOCK];
    end
  end

  // Go and request pulses land in the cycle after ack
  always_ff @(posedge clk or negedge mci_pwrgood) begin
    if (!mci_pwrgood) begin
      bootfsm_go_q  <= 1'b0;
      mcu_rst_req_q <= 1'b0;
    end else begin
      bootfsm_go_q  <= pulse_fire && wb_i.dat[CTRL_BOOTFSM_GO];
      mcu_rst_req_q <= pulse_fire && wb_i.dat[CTRL_MCU_RST_REQ];
    end
  end

  assign ctrl_o.bootfsm_go    = bootfsm_go_q;
  assign ctrl_o.cptra_boot_go = cptra_go_q;
  assign ctrl_o.mcu_rst_req   = mcu_rst_req_q;
  assign ctrl_o.region_lock   = region_lock_q;

  ////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (wb_i.adr)
      ADDR_CTRL: begin
        // Pulse bits always read back as zero
        rd_data[CTRL_CPTRA_GO]    = cptra_go_q;
        rd_data[CTRL_REGION_LOCK] = region_lock_q;
      end
      ADDR_STATUS: begin
        rd_data[STAT_STATE_LSB +: $bits(mci_boot_fsm_state_e)] = status_i.state;
        rd_data[STAT_MCU_RST_ONCE] = status_i.mcu_reset_once;
        rd_data[STAT_SS_RST_B]     = status_i.ss_rst_b;
        rd_data[STAT_MCU_RST_B]    = status_i.mcu_rst_b;
        rd_data[STAT_CPTRA_RST_B]  = status_i.cptra_rst_b;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rd_q <= rd_data;
    end
  end

  assign wb_o.dat = rd_q;
  assign wb_o.ack = ack_q;

  ////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////

  // Master drops the strobe for a cycle after each ack, so every ack answers a new transfer
  a_stb_gap: assert property (
    @(posedge clk) disable iff (!mci_pwrgood)
    wb_o.ack |=> !wb_i.stb
  );

endmodule

// File: mci_in_sync.sv
/*
 * Synchronizer bank for the asynchronous SoC pins and the warm reset window
 */
module mci_in_sync
  import mci_pkg::*;
(
  input  logic      clk,
  input  logic      mci_pwrgood,
  input  logic      mci_rst_b,
  input  logic      brkpoint_i,
  input  logic      no_rom_config_i,
  input  logic      halt_ack_i,
  input  logic      halt_status_i,
  output soc_sync_t sync_o
);

  logic       rst_window;
  logic [1:0] window_ff;
  logic [3:0] pin_in;
  logic [3:0] pin_meta;
  logic [3:0] pin_sync;

  assign pin_in = {brkpoint_i, no_rom_config_i, halt_ack_i, halt_status_i};

  // Window opens as soon as warm reset asserts, closes on the first edge after release
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      rst_window <= 1'b1;
    end else begin
      rst_window <= 1'b0;
    end
  end

  // Window copy comes out of power-good reset asserted
  always_ff @(posedge clk or negedge mci_pwrgood) begin
    if (!mci_pwrgood) begin
      window_ff <= 2'b11;
    end else begin
      window_ff <= {window_ff[0], rst_window};
    end
  end

  always_ff @(posedge clk or negedge mci_pwrgood) begin
    if (!mci_pwrgood) begin
      pin_meta <= '0;
      pin_sync <= '0;
    end else begin
      pin_meta <= pin_in;
      pin_sync <= pin_meta;
    end
  end

  assign sync_o.brkpoint        = pin_sync[3];
  assign sync_o.no_rom_config   = pin_sync[2];
  assign sync_o.halt_ack        = pin_sync[1];
  assign sync_o.halt_status     = pin_sync[0];
  assign sync_o.warm_rst_window = window_ff[1];

endmodule

// File: mci_pkg.sv
/*
 * Shared definitions for the MCI boot sequencing subsystem: data widths,
 * boot FSM state encoding, register map and the structs between blocks
 */
package mci_pkg;

  ////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////

  // MCU stays in reset for at least 2**MIN_MCU_RST_CNT_W cycles on FW update
  localparam int MIN_MCU_RST_CNT_W = 4;
  localparam int WB_DATA_W         = 32;
  localparam int WB_ADDR_W         = 4;

  typedef logic [MIN_MCU_RST_CNT_W-1:0] rst_cnt_t;
  typedef logic [WB_DATA_W-1:0]         wb_data_t;
  typedef logic [WB_ADDR_W-1:0]         wb_addr_t;

  ////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////

  localparam wb_addr_t ADDR_CTRL   = 4'd0;
  localparam wb_addr_t ADDR_STATUS = 4'd1;

  // CTRL: bits 0 and 2 are write-one pulses, bits 1 and 3 are levels
  localparam int CTRL_BOOTFSM_GO  = 0;
  localparam int CTRL_CPTRA_GO    = 1;
  localparam int CTRL_MCU_RST_REQ = 2;
  localparam int CTRL_REGION_LOCK = 3;

  // STATUS
  localparam int STAT_STATE_LSB     = 0;
  localparam int STAT_MCU_RST_ONCE  = 8;
  localparam int STAT_SS_RST_B      = 16;
  localparam int STAT_MCU_RST_B     = 17;
  localparam int STAT_CPTRA_RST_B   = 18;

  ////////////////////////////////////////////////////
  // Boot FSM
  ////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    BOOT_IDLE,
    BOOT_OTP_FC,
    BOOT_LCC,
    BOOT_BREAKPOINT_CHECK,
    BOOT_BREAKPOINT,
    BOOT_MCU,
    BOOT_WAIT_CPTRA_GO,
    BOOT_CPTRA,
    BOOT_WAIT_MCU_RST_REQ,
    BOOT_HALT_MCU,
    BOOT_WAIT_MCU_HALTED,
    BOOT_RST_MCU,
    BOOT_UNKNOWN
  } mci_boot_fsm_state_e;

  ////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    wb_data_t dat;
    logic     ack;
  } wb_rsp_t;

  typedef struct packed {
    logic brkpoint;
    logic no_rom_config;
    logic halt_ack;
    logic halt_status;
    logic warm_rst_window;
  } soc_sync_t;

  typedef struct packed {
    logic bootfsm_go;
    logic cptra_boot_go;
    logic mcu_rst_req;
    logic region_lock;
  } boot_ctrl_t;

  typedef struct packed {
    mci_boot_fsm_state_e state;
    logic                mcu_reset_once;
    logic                ss_rst_b;
    logic                mcu_rst_b;
    logic                cptra_rst_b;
  } boot_status_t;

endpackage
